/* Bender.yml */
package:
  name: hxdsoc_loader

sources:
  - files:
      - common/soc_cfg_pkg.sv
      - common/loader_pkg.sv
      - spi_slave/spi_slave.sv
      - ram_rw/ram_rw.sv
      - verilog/ram_bank.sv
      - verilog/hxdsoc_loader.sv
  - target: simulation
    files:
      - dv/tb_hxdsoc_loader.sv

/* common/loader_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Host command codes, loader FSM states and the RAM bank write bundle.
////////////////////////////////////////////////////////////////////////////

package loader_pkg;

    // Command bytes sent by the host while dc_i is low.
    typedef enum logic [7:0] {
        CMD_CPU_RUN = 8'h01,
        CMD_CPU_RST = 8'h02,
        CMD_IRAM_WR = 8'h03,
        CMD_IRAM_RD = 8'h04,
        CMD_DRAM_WR = 8'h05,
        CMD_DRAM_RD = 8'h06
    } host_cmd_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_IRAM_WR,
        ST_IRAM_RD,
        ST_DRAM_WR,
        ST_DRAM_RD
    } loader_state_e;

    // One byte write into a bank; data carries the byte on every lane.
    typedef struct packed {
        logic                  en;
        soc_cfg_pkg::xlen_t    addr;
        soc_cfg_pkg::byte_en_t byte_en;
        soc_cfg_pkg::xlen_t    data;
    } ram_wr_t;

endpackage

/* common/soc_cfg_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Machine word, SPI byte and byte-lane widths with their vector types,
// shared by the loader, the RAM banks and a later core.
////////////////////////////////////////////////////////////////////////////

package soc_cfg_pkg;

    // Data word width of the system.
    localparam int XLEN = 32;

    // RAM words and byte addresses.
    typedef logic [XLEN-1:0] xlen_t;

    // One byte as it travels over SPI.
    typedef logic [7:0] byte_t;

    // One enable per byte lane of a word.
    typedef logic [XLEN/8-1:0] byte_en_t;

endpackage

/* dv/loader_cases.txt */
# kind hex [hex]: C command byte, W data byte written, R expected reply byte,
# S cpu_rst_n_o level, I and M core-port byte address and expected iram/dram word.
S 0
C 01
S 1
C 03
S 0
W 11
W 22
W 33
W 44
W 55
I 00000000 44332211
C 05
W a1
W b2
W c3
W d4
M 00000000 d4c3b2a1
I 00000000 44332211
C 04
R 11
R 22
R 33
R 44
R 55
C 06
R a1
R b2
C 03
W 99
I 00000000 44332299
C 04
R 99
R 22

/* dv/tb_hxdsoc_loader.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the host loader: clock, reset, SPI master driver,
// case-file reader, compare tasks and a cycle-count timeout.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_hxdsoc_loader;

localparam int RAM_AW          = 6;
localparam int HALF_SCLK       = 8;                        // clk_i cycles per SCLK half period.
localparam int CYCLES_PER_CASE = 200;

logic               clk;
logic               arst_n;
logic               dc;
logic               sclk;
logic               mosi;
logic               cs_n;
logic               miso;
logic               cpu_rst_n;
soc_cfg_pkg::xlen_t iram_rd_addr;
soc_cfg_pkg::xlen_t dram_rd_addr;
soc_cfg_pkg::xlen_t iram_rd_data;
soc_cfg_pkg::xlen_t dram_rd_data;

logic [7:0]         kind_q [$];
soc_cfg_pkg::xlen_t val_a_q [$];
soc_cfg_pkg::xlen_t val_b_q [$];

int unsigned cycle_cnt   = 0;
int unsigned cycle_limit = 0;                              // Set once the cases are known.

hxdsoc_loader #(
    .RAM_AW (RAM_AW)
) dut0 (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .dc_i           (dc),
    .spi_sclk_i     (sclk),
    .spi_mosi_i     (mosi),
    .spi_cs_n_i     (cs_n),
    .iram_rd_addr_i (iram_rd_addr),
    .dram_rd_addr_i (dram_rd_addr),
    .spi_miso_o     (miso),
    .cpu_rst_n_o    (cpu_rst_n),
    .iram_rd_data_o (iram_rd_data),
    .dram_rd_data_o (dram_rd_data)
);

initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
        $display("The run did not finish within %0d clock cycles.", cycle_limit);
        $display("Simulation FAILED");
        $fatal(1, "Timeout.");
    end
end

// Returns 2 ns after the n-th rising edge, where inputs change and outputs are stable.
task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk);
    #2;
endtask

task automatic report_mismatch(input string what, input string got, input string exp);
    $display("error at %0t ns: %s gave %s, expected %s", $time, what, got, exp);
    $display("Simulation FAILED");
    $fatal(1, "Stopped at the first mismatch.");
endtask

task automatic check_byte(input soc_cfg_pkg::byte_t got, input soc_cfg_pkg::byte_t exp,
                          input string what);
    if (got !== exp) begin
        report_mismatch(what, $sformatf("%h", got), $sformatf("%h", exp));
    end
endtask

task automatic check_word(input soc_cfg_pkg::xlen_t got, input soc_cfg_pkg::xlen_t exp,
                          input string what);
    if (got !== exp) begin
        report_mismatch(what, $sformatf("%h", got), $sformatf("%h", exp));
    end
endtask

task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        report_mismatch(what, $sformatf("%b", got), $sformatf("%b", exp));
    end
endtask

// Mode 0, MSB first. MISO is taken just before each rising SCLK edge.
task automatic spi_transfer(input logic dc_level, input soc_cfg_pkg::byte_t tx,
                            output soc_cfg_pkg::byte_t rx);
    int gap;
    rx   = '0;
    dc   = dc_level;
    cs_n = 1'b0;
    wait_clocks(HALF_SCLK);
    for (int i = 7; i >= 0; i--) begin
        mosi = tx[i];
        wait_clocks(HALF_SCLK);
        rx[i] = miso;
        sclk  = 1'b1;
        wait_clocks(HALF_SCLK);
        sclk  = 1'b0;
    end
    wait_clocks(HALF_SCLK);
    cs_n = 1'b1;
    gap  = 4 + ($urandom % 17);
    wait_clocks(gap);
endtask

task automatic load_cases();
    int                 fd;
    int                 code;
    logic [7:0]         kind;
    soc_cfg_pkg::xlen_t a;
    soc_cfg_pkg::xlen_t b;
    string              rest;
    fd = $fopen("dv/loader_cases.txt", "r");
    if (fd == 0) begin
        $display("The case file dv/loader_cases.txt could not be opened.");
        $display("Simulation FAILED");
        $fatal(1, "No cases.");
    end else begin
        while ($fscanf(fd, " %c", kind) == 1) begin
            if (kind == "#") begin
                code = $fgets(rest, fd);                   // Comment line.
            end else begin
                a    = '0;
                b    = '0;
                code = $fscanf(fd, "%h", a);
                if (kind == "I" || kind == "M") begin
                    code = $fscanf(fd, "%h", b);
                end
                kind_q.push_back(kind);
                val_a_q.push_back(a);
                val_b_q.push_back(b);
            end
        end
        $fclose(fd);
    end
endtask

initial begin : main_seq
    soc_cfg_pkg::byte_t reply;
    string              what;
    void'($urandom(32'h84f3));
    arst_n       = 1'b0;
    dc           = 1'b0;
    sclk         = 1'b0;
    mosi         = 1'b0;
    cs_n         = 1'b1;
    iram_rd_addr = '0;
    dram_rd_addr = '0;
    load_cases();
    cycle_limit = kind_q.size() * CYCLES_PER_CASE;
    wait_clocks(8);
    arst_n = 1'b1;
    wait_clocks(2);
    for (int n = 0; n < kind_q.size(); n++) begin
        what = $sformatf("case %0d (%c)", n + 1, kind_q[n]);
        case (kind_q[n])
            "C": spi_transfer(1'b0, val_a_q[n][7:0], reply);
            "W": spi_transfer(1'b1, val_a_q[n][7:0], reply);
            "R": begin
                spi_transfer(1'b1, 8'h00, reply);
                check_byte(reply, val_a_q[n][7:0], what);
            end
            "I": begin
                iram_rd_addr = val_a_q[n];
                wait_clocks(1);                            // One cycle read latency.
                check_word(iram_rd_data, val_b_q[n], what);
            end
            "M": begin
                dram_rd_addr = val_a_q[n];
                wait_clocks(1);
                check_word(dram_rd_data, val_b_q[n], what);
            end
            "S": check_level(cpu_rst_n, val_a_q[n][0], what);
            default: begin
                $display("The case file holds a line of unknown kind at %s.", what);
                $display("Simulation FAILED");
                $fatal(1, "Bad case file.");
            end
        endcase
    end
    $display("Simulation PASSED");
    $finish;
end

endmodule

/* ram_rw/ram_rw.sv */
////////////////////////////////////////////////////////////////////////////
// Loader controller: decodes host commands, steps the byte address,
// drives bank writes and merges bank read words into reply bytes.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ram_rw #(
    parameter int RAM_AW = 6
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,

    input  logic                 dc_i,

    input  logic                 spi_byte_vld_i,
    input  soc_cfg_pkg::byte_t   spi_byte_data_i,

    input  soc_cfg_pkg::xlen_t   iram_rd_data_i,
    input  soc_cfg_pkg::xlen_t   dram_rd_data_i,

    output logic                 cpu_rst_n_o,

    output logic                 spi_byte_rdy_o,
    output soc_cfg_pkg::byte_t   spi_byte_data_o,

    output loader_pkg::ram_wr_t  iram_wr_o,
    output loader_pkg::ram_wr_t  dram_wr_o,
    output soc_cfg_pkg::xlen_t   ram_rd_addr_o
);

loader_pkg::loader_state_e state_q;
loader_pkg::host_cmd_e     cmd;

logic [1:0]        dc_sync_q;
logic [RAM_AW+1:0] addr_q;                                 // Byte address, wraps at bank size.

logic cmd_vld, dat_vld, wr_fire, rd_start, rd_state;
logic rd_pend1_q, rd_pend2_q;

logic                  iram_wr_en_q;
logic                  dram_wr_en_q;
soc_cfg_pkg::xlen_t    wr_addr_q;
soc_cfg_pkg::byte_en_t wr_be_q;
soc_cfg_pkg::xlen_t    wr_data_q;
soc_cfg_pkg::xlen_t    rd_word;

assign cmd      = loader_pkg::host_cmd_e'(spi_byte_data_i);
assign cmd_vld  = spi_byte_vld_i & ~dc_sync_q[1];
assign dat_vld  = spi_byte_vld_i &  dc_sync_q[1];
assign rd_state = (state_q == loader_pkg::ST_IRAM_RD) | (state_q == loader_pkg::ST_DRAM_RD);
assign wr_fire  = dat_vld & ((state_q == loader_pkg::ST_IRAM_WR) |
                             (state_q == loader_pkg::ST_DRAM_WR));
assign rd_start = (cmd_vld & ((cmd == loader_pkg::CMD_IRAM_RD) |
                              (cmd == loader_pkg::CMD_DRAM_RD))) |
                  (dat_vld & rd_state);

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        dc_sync_q      <= '0;
        state_q        <= loader_pkg::ST_IDLE;
        cpu_rst_n_o    <= 1'b0;
        addr_q         <= '0;
        iram_wr_en_q   <= 1'b0;
        dram_wr_en_q   <= 1'b0;
        rd_pend1_q     <= 1'b0;
        rd_pend2_q     <= 1'b0;
        spi_byte_rdy_o <= 1'b0;
        ram_rd_addr_o  <= '0;
    end else begin
        dc_sync_q      <= {dc_sync_q[0], dc_i};
        iram_wr_en_q   <= wr_fire & (state_q == loader_pkg::ST_IRAM_WR);
        dram_wr_en_q   <= wr_fire & (state_q == loader_pkg::ST_DRAM_WR);
        rd_pend1_q     <= rd_start;
        rd_pend2_q     <= rd_pend1_q;                      // Bank word is valid with this one.
        spi_byte_rdy_o <= rd_pend2_q;
        if (rd_pend2_q) begin
            addr_q <= addr_q + 1'b1;
        end
        if (rd_start) begin
            ram_rd_addr_o <= cmd_vld ? '0 : soc_cfg_pkg::xlen_t'(addr_q);
        end
        if (cmd_vld) begin
            addr_q <= '0;
            case (cmd)
                loader_pkg::CMD_CPU_RUN: begin
                    state_q     <= loader_pkg::ST_IDLE;
                    cpu_rst_n_o <= 1'b1;
                end
                loader_pkg::CMD_CPU_RST: begin
                    state_q     <= loader_pkg::ST_IDLE;
                    cpu_rst_n_o <= 1'b0;
                end
                loader_pkg::CMD_IRAM_WR: begin
                    state_q     <= loader_pkg::ST_IRAM_WR;
                    cpu_rst_n_o <= 1'b0;
                end
                loader_pkg::CMD_IRAM_RD: begin
                    state_q     <= loader_pkg::ST_IRAM_RD;
                    cpu_rst_n_o <= 1'b0;
                end
                loader_pkg::CMD_DRAM_WR: begin
                    state_q     <= loader_pkg::ST_DRAM_WR;
                    cpu_rst_n_o <= 1'b0;
                end
                loader_pkg::CMD_DRAM_RD: begin
                    state_q     <= loader_pkg::ST_DRAM_RD;
                    cpu_rst_n_o <= 1'b0;
                end
                default: state_q <= loader_pkg::ST_IDLE;   // Unknown code keeps the core as is.
            endcase
        end else if (wr_fire) begin
            addr_q <= addr_q + 1'b1;
        end
    end
end

always_ff @(posedge clk_i) begin
    if (wr_fire) begin
        wr_addr_q <= soc_cfg_pkg::xlen_t'(addr_q);
        wr_be_q   <= soc_cfg_pkg::byte_en_t'(4'b0001 << addr_q[1:0]);
        wr_data_q <= {4{spi_byte_data_i}};
    end
end

always_comb begin
    iram_wr_o = '{en: iram_wr_en_q, addr: wr_addr_q, byte_en: wr_be_q, data: wr_data_q};
    dram_wr_o = '{en: dram_wr_en_q, addr: wr_addr_q, byte_en: wr_be_q, data: wr_data_q};
end

// Word of the bank being read, then its lane from the address sent two cycles back.
assign rd_word = (state_q == loader_pkg::ST_DRAM_RD) ? dram_rd_data_i : iram_rd_data_i;

always_ff @(posedge clk_i) begin
    if (rd_pend2_q) begin
        spi_byte_data_o <= rd_word[{ram_rd_addr_o[1:0], 3'b000} +: 8];
    end
end

a_wr_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(iram_wr_o.en && dram_wr_o.en));

a_rdy_in_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    spi_byte_rdy_o |-> rd_state);

endmodule

/* spi_slave/spi_slave.sv */
////////////////////////////////////////////////////////////////////////////
// SPI mode-0 byte slave, MSB first, oversampled on clk_i.
// Receives bytes from MOSI and returns the loaded reply byte on MISO.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module spi_slave (
    input  logic                clk_i,
    input  logic                arst_n_i,

    input  logic                spi_sclk_i,
    input  logic                spi_mosi_i,
    input  logic                spi_cs_n_i,

    input  logic                spi_byte_rdy_i,
    input  soc_cfg_pkg::byte_t  spi_byte_data_i,

    output logic                spi_miso_o,

    output logic                spi_byte_vld_o,
    output soc_cfg_pkg::byte_t  spi_byte_data_o
);

logic [1:0] sclk_sync_q;
logic [1:0] mosi_sync_q;
logic [1:0] cs_n_sync_q;
logic       sclk_d_q;

logic       sclk_rise;
logic       sclk_fall;
logic       cs_n_s;

logic [2:0]         bit_cnt_q;
soc_cfg_pkg::byte_t rx_q;
soc_cfg_pkg::byte_t tx_q;
soc_cfg_pkg::byte_t tx_next_q;

assign cs_n_s    = cs_n_sync_q[1];
assign sclk_rise =  sclk_sync_q[1] & ~sclk_d_q & ~cs_n_s;
assign sclk_fall = ~sclk_sync_q[1] &  sclk_d_q & ~cs_n_s;

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        sclk_sync_q <= '0;
        mosi_sync_q <= '0;
        cs_n_sync_q <= '1;                                 // Deselected until the pins say otherwise.
        sclk_d_q    <= 1'b0;
    end else begin
        sclk_sync_q <= {sclk_sync_q[0], spi_sclk_i};
        mosi_sync_q <= {mosi_sync_q[0], spi_mosi_i};
        cs_n_sync_q <= {cs_n_sync_q[0], spi_cs_n_i};
        sclk_d_q    <= sclk_sync_q[1];
    end
end

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        bit_cnt_q      <= '0;
        spi_byte_vld_o <= 1'b0;
    end else begin
        spi_byte_vld_o <= sclk_rise & (bit_cnt_q == 3'd7); // Eighth bit just came in.
        if (cs_n_s) begin
            bit_cnt_q <= '0;
        end else if (sclk_rise) begin
            bit_cnt_q <= bit_cnt_q + 3'd1;
        end
    end
end

always_ff @(posedge clk_i) begin
    if (sclk_rise) begin
        rx_q <= {rx_q[6:0], mosi_sync_q[1]};
    end
end

assign spi_byte_data_o = rx_q;

// The falling edge that closes a byte moves the pending reply into the shifter.
always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        tx_q      <= '0;
        tx_next_q <= '0;
    end else begin
        if (spi_byte_rdy_i) begin
            tx_next_q <= spi_byte_data_i;
        end else if (sclk_fall && bit_cnt_q == 3'd0) begin
            tx_next_q <= '0;                               // Nothing new means 0x00 next time.
        end
        if (sclk_fall) begin
            tx_q <= (bit_cnt_q == 3'd0) ? tx_next_q : {tx_q[6:0], 1'b0};
        end
    end
end

assign spi_miso_o = tx_q[7];

a_vld_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    spi_byte_vld_o |=> !spi_byte_vld_o);

endmodule

/* tb.f */
common/soc_cfg_pkg.sv
common/loader_pkg.sv
spi_slave/spi_slave.sv
ram_rw/ram_rw.sv
verilog/ram_bank.sv
verilog/hxdsoc_loader.sv
dv/tb_hxdsoc_loader.sv

/* verilog/hxdsoc_loader.sv */
////////////////////////////////////////////////////////////////////////////
// Host loader top: SPI slave, loader controller, instruction and data
// RAM banks, with read ports and reset left open for a core.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hxdsoc_loader #(
    parameter int RAM_AW = 6
) (
    input  logic               clk_i,
    input  logic               arst_n_i,

    input  logic               dc_i,

    input  logic               spi_sclk_i,
    input  logic               spi_mosi_i,
    input  logic               spi_cs_n_i,

    input  soc_cfg_pkg::xlen_t iram_rd_addr_i,
    input  soc_cfg_pkg::xlen_t dram_rd_addr_i,

    output logic               spi_miso_o,
    output logic               cpu_rst_n_o,

    output soc_cfg_pkg::xlen_t iram_rd_data_o,
    output soc_cfg_pkg::xlen_t dram_rd_data_o
);

logic               spi_byte_vld;
logic               spi_byte_rdy;
soc_cfg_pkg::byte_t spi_rx_byte;
soc_cfg_pkg::byte_t spi_tx_byte;

loader_pkg::ram_wr_t iram_wr;
loader_pkg::ram_wr_t dram_wr;

soc_cfg_pkg::xlen_t ram_rd_addr;
soc_cfg_pkg::xlen_t iram_rd_data_b;
soc_cfg_pkg::xlen_t dram_rd_data_b;

spi_slave spi_slave0 (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .spi_sclk_i      (spi_sclk_i),
    .spi_mosi_i      (spi_mosi_i),
    .spi_cs_n_i      (spi_cs_n_i),
    .spi_byte_rdy_i  (spi_byte_rdy),
    .spi_byte_data_i (spi_tx_byte),
    .spi_miso_o      (spi_miso_o),
    .spi_byte_vld_o  (spi_byte_vld),
    .spi_byte_data_o (spi_rx_byte)
);

ram_rw #(
    .RAM_AW (RAM_AW)
) ram_rw0 (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .dc_i            (dc_i),
    .spi_byte_vld_i  (spi_byte_vld),
    .spi_byte_data_i (spi_rx_byte),
    .iram_rd_data_i  (iram_rd_data_b),
    .dram_rd_data_i  (dram_rd_data_b),
    .cpu_rst_n_o     (cpu_rst_n_o),
    .spi_byte_rdy_o  (spi_byte_rdy),
    .spi_byte_data_o (spi_tx_byte),
    .iram_wr_o       (iram_wr),
    .dram_wr_o       (dram_wr),
    .ram_rd_addr_o   (ram_rd_addr)
);

ram_bank #(
    .RAM_AW (RAM_AW)
) iram0 (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .wr_i        (iram_wr),
    .rd_addr_a_i (iram_rd_addr_i),
    .rd_addr_b_i (ram_rd_addr),
    .rd_data_a_o (iram_rd_data_o),
    .rd_data_b_o (iram_rd_data_b)
);

ram_bank #(
    .RAM_AW (RAM_AW)
) dram0 (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .wr_i        (dram_wr),
    .rd_addr_a_i (dram_rd_addr_i),
    .rd_addr_b_i (ram_rd_addr),
    .rd_data_a_o (dram_rd_data_o),
    .rd_data_b_o (dram_rd_data_b)
);

endmodule

/* verilog/ram_bank.sv */
////////////////////////////////////////////////////////////////////////////
// Word RAM with byte-lane writes and two registered read ports.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ram_bank #(
    parameter int RAM_AW = 6
) (
    input  logic                clk_i,
    input  logic                arst_n_i,

    input  loader_pkg::ram_wr_t wr_i,

    input  soc_cfg_pkg::xlen_t  rd_addr_a_i,
    input  soc_cfg_pkg::xlen_t  rd_addr_b_i,

    output soc_cfg_pkg::xlen_t  rd_data_a_o,
    output soc_cfg_pkg::xlen_t  rd_data_b_o
);

localparam int DEPTH = 2 ** RAM_AW;

soc_cfg_pkg::xlen_t mem [DEPTH];

logic [RAM_AW-1:0] wr_idx;
logic [RAM_AW-1:0] rd_idx_a;
logic [RAM_AW-1:0] rd_idx_b;

// Byte address bits above the lane select pick the word.
assign wr_idx   = wr_i.addr[RAM_AW+1:2];
assign rd_idx_a = rd_addr_a_i[RAM_AW+1:2];
assign rd_idx_b = rd_addr_b_i[RAM_AW+1:2];

always_ff @(posedge clk_i) begin
    if (wr_i.en) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_i.byte_en[i]) begin
                mem[wr_idx][i*8 +: 8] <= wr_i.data[i*8 +: 8];
            end
        end
    end
end

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        rd_data_a_o <= '0;
        rd_data_b_o <= '0;
    end else begin
        rd_data_a_o <= mem[rd_idx_a];                      // Core port.
        rd_data_b_o <= mem[rd_idx_b];                      // Loader port.
    end
end

endmodule
